// ==== dispatchDecode.sv ====
`default_nettype none
`include "iq_cfg.svh"

module dispatchDecode (
    input  iqPkg::renameUop_t [`IQ_DISPATCH-1:0] dispatch,
    input  logic [$clog2(`IQ_SIZE+1)-1:0]        freeSlots,
    input  iqPkg::branch_t                       branch,
    output logic [`IQ_DISPATCH-1:0]              stall,
    output iqPkg::iqEntry_t [`IQ_DISPATCH-1:0]   enqEntries,
    output logic [`IQ_DISPATCH-1:0]              enqValid
);

    localparam int cntW = $clog2(`IQ_SIZE + 1);

    // Queue form of a rename uop, an immediate B never waits
    function automatic iqPkg::iqEntry_t toEntry(iqPkg::renameUop_t u);
        iqPkg::iqEntry_t e;
        e.aluOp  = u.aluOp;
        e.tagA   = u.tagA;
        e.availA = u.availA;
        e.opB    = u.opB;
        e.immB   = u.immB;
        e.availB = u.availB | u.immB;
        e.tagDst = u.tagDst;
        e.sqN    = u.sqN;
        return e;
    endfunction

    always_comb begin
        logic [cntW-1:0] granted;
        granted = '0;
        for (int i = 0; i < `IQ_DISPATCH; i++) begin
            stall[i]      = 1'b0;
            enqValid[i]   = 1'b0;
            enqEntries[i] = toEntry(dispatch[i]);

            // Uops for other ports pass by without stalling
            if (dispatch[i].valid && dispatch[i].port == iqPkg::PORT_INT) begin
                if (!branch.taken && granted < freeSlots) begin
                    enqValid[i] = 1'b1;
                    granted     = granted + 1'b1;
                end else begin
                    // Older slots used up the room, or a flush is in progress
                    stall[i] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
iqPkg.sv
dispatchDecode.sv
issueQueue.sv
intExecute.sv
resultWriteback.sv
issueTop.sv
issueChecker.sv
issue_asserts.sv
issueTb.sv

// ==== intExecute.sv ====
`default_nettype none
`include "iq_cfg.svh"

module intExecute (
    input  logic                     clk,
    input  logic                     rst,
    input  iqPkg::issueUop_t         issued,
    input  iqPkg::branch_t           branch,
    output iqPkg::tag_t              readTagA,
    output iqPkg::tag_t              readTagB,
    input  logic [`IQ_DATA_BITS-1:0] readDataA,
    input  logic [`IQ_DATA_BITS-1:0] readDataB,
    input  iqPkg::result_t           bcast,
    output iqPkg::result_t           exResult
);

    localparam int shW = $clog2(`IQ_DATA_BITS);

    logic [`IQ_DATA_BITS-1:0] srcA;
    logic [`IQ_DATA_BITS-1:0] srcB;
    logic [`IQ_DATA_BITS-1:0] aluOut;

    // Newest value wins: own result, then broadcast, then register file
    function automatic logic [`IQ_DATA_BITS-1:0] bypass(
        iqPkg::tag_t t, logic [`IQ_DATA_BITS-1:0] rf,
        iqPkg::result_t ex, iqPkg::result_t bc);
        logic [`IQ_DATA_BITS-1:0] v;
        v = rf;
        if (bc.valid && bc.tagDst == t) v = bc.value;
        if (ex.valid && ex.tagDst == t) v = ex.value;
        return v;
    endfunction

    assign readTagA = issued.tagA;
    assign readTagB = issued.opB.tagView.tag;

    always_comb begin
        srcA = bypass(readTagA, readDataA, exResult, bcast);
        if (issued.immB) begin
            srcB = {{(`IQ_DATA_BITS-8){issued.opB.imm[7]}}, issued.opB.imm};
        end else begin
            srcB = bypass(readTagB, readDataB, exResult, bcast);
        end

        case (issued.aluOp)
            iqPkg::ALU_ADD: aluOut = srcA + srcB;
            iqPkg::ALU_SUB: aluOut = srcA - srcB;
            iqPkg::ALU_AND: aluOut = srcA & srcB;
            iqPkg::ALU_OR:  aluOut = srcA | srcB;
            iqPkg::ALU_XOR: aluOut = srcA ^ srcB;
            iqPkg::ALU_SLL: aluOut = srcA << srcB[shW-1:0];
            iqPkg::ALU_SLT: aluOut = `IQ_DATA_BITS'($signed(srcA) < $signed(srcB));
            default:        aluOut = srcB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exResult.valid <= 1'b0;
        end else begin
            // Wrong-path ops and ops without destination produce nothing
            exResult.valid <= issued.valid && issued.tagDst != iqPkg::NO_TAG
                && !(branch.taken && iqPkg::isYounger(issued.sqN, branch.sqN));
            exResult.tagDst <= issued.tagDst;
            exResult.value  <= aluOut;
        end
    end

endmodule

`default_nettype wire

// ==== iqPkg.sv ====
`default_nettype none
`include "iq_cfg.svh"

package iqPkg;

    typedef logic [`IQ_TAG_BITS-1:0] tag_t;
    typedef logic [`IQ_SQN_BITS-1:0] sqn_t;

    localparam tag_t NO_TAG = '1;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SLT,
        ALU_PASSB
    } aluOp_e;

    // Only the integer port exists in this subsystem
    typedef enum logic [1:0] {
        PORT_INT,
        PORT_LSU,
        PORT_FPU,
        PORT_CSR
    } portSel_e;

    typedef struct packed {
        logic [7-`IQ_TAG_BITS:0] pad;
        tag_t                    tag;
    } tagView_t;

    // Operand B is a source tag or a short immediate, immB picks the view
    typedef union packed {
        tagView_t   tagView;
        logic [7:0] imm;
    } operandB_u;

    typedef struct packed {
        logic      valid;
        portSel_e  port;
        aluOp_e    aluOp;
        tag_t      tagA;
        logic      availA;
        operandB_u opB;
        logic      immB;
        logic      availB;
        tag_t      tagDst;
        sqn_t      sqN;
    } renameUop_t;

    typedef struct packed {
        aluOp_e    aluOp;
        tag_t      tagA;
        logic      availA;
        operandB_u opB;
        logic      immB;
        logic      availB;
        tag_t      tagDst;
        sqn_t      sqN;
    } iqEntry_t;

    typedef struct packed {
        logic      valid;
        aluOp_e    aluOp;
        tag_t      tagA;
        operandB_u opB;
        logic      immB;
        tag_t      tagDst;
        sqn_t      sqN;
    } issueUop_t;

    typedef struct packed {
        logic                     valid;
        tag_t                     tagDst;
        logic [`IQ_DATA_BITS-1:0] value;
    } result_t;

    typedef struct packed {
        logic taken;
        sqn_t sqN;
    } branch_t;

    // True when a was dispatched after b
    function automatic logic isYounger(sqn_t a, sqn_t b);
        sqn_t diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire

// ==== iq_cfg.svh ====
`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// Issue queue depth in entries
`define IQ_SIZE 8

// Micro-ops accepted from rename per cycle
`define IQ_DISPATCH 2

// Physical register tag width, all-ones tag means no destination
`define IQ_TAG_BITS 6

// Register and result width
`define IQ_DATA_BITS 32

// Sequence number width, ages compared by signed difference
`define IQ_SQN_BITS 6

`endif

// ==== issueChecker.sv ====
`default_nettype none
`include "iq_cfg.svh"

module issueChecker (
    input  logic                     clk,
    input  logic                     rst,
    input  iqPkg::result_t           result,
    input  logic [1:0]               expState [2**`IQ_TAG_BITS],
    input  logic [`IQ_DATA_BITS-1:0] expValue [2**`IQ_TAG_BITS],
    input  logic                     endScan,
    output int                       seenCount,
    output int                       valueErrors,
    output int                       otherErrors
);

    localparam int numTags = 2 ** `IQ_TAG_BITS;

    logic seen [numTags];

    // State 1 means expected, state 2 means flushed
    task automatic checkResult(iqPkg::result_t r);
        case (expState[r.tagDst])
            2'd1: begin
                if (seen[r.tagDst]) begin
                    $display("Tag %0d was broadcast a second time at %0t", r.tagDst, $time);
                    otherErrors++;
                end else begin
                    seen[r.tagDst] = 1'b1;
                    seenCount++;
                end
                if (r.value !== expValue[r.tagDst]) begin
                    $display("FAILED %0t result.value tag %0d got %h expected %h",
                        $time, r.tagDst, r.value, expValue[r.tagDst]);
                    valueErrors++;
                end
            end
            2'd2: begin
                $display("Flushed tag %0d was broadcast at %0t", r.tagDst, $time);
                otherErrors++;
            end
            default: begin
                $display("Tag %0d that no uop produces was broadcast at %0t", r.tagDst, $time);
                otherErrors++;
            end
        endcase
    endtask

    task automatic scanMissing;
        for (int t = 0; t < numTags; t++) begin
            if (expState[t] == 2'd1 && !seen[t]) begin
                $display("Expected tag %0d never appeared on the result bus", t);
                otherErrors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            seenCount   = 0;
            valueErrors = 0;
            otherErrors = 0;
            for (int t = 0; t < numTags; t++) seen[t] = 1'b0;
        end else begin
            if (result.valid) checkResult(result);
            if (endScan) scanMissing();
        end
    end

endmodule

`default_nettype wire

// ==== issueQueue.sv ====
`default_nettype none
`include "iq_cfg.svh"

module issueQueue (
    input  logic                               clk,
    input  logic                               rst,
    input  iqPkg::iqEntry_t [`IQ_DISPATCH-1:0] enqEntries,
    input  logic [`IQ_DISPATCH-1:0]            enqValid,
    input  iqPkg::branch_t                     branch,
    input  logic                               issueStall,
    input  iqPkg::result_t                     bcast,
    input  iqPkg::issueUop_t                   fastWake,
    output logic [$clog2(`IQ_SIZE+1)-1:0]      freeSlots,
    output iqPkg::issueUop_t                   issued
);

    localparam int cntW = $clog2(`IQ_SIZE + 1);
    localparam int idxW = $clog2(`IQ_SIZE);

    // Entries kept oldest-first, index 0 is the oldest
    iqPkg::iqEntry_t  queue [`IQ_SIZE];
    iqPkg::iqEntry_t  qNext [`IQ_SIZE];
    logic [cntW-1:0]  count;
    logic [cntW-1:0]  countNext;
    iqPkg::issueUop_t issueReg;
    iqPkg::issueUop_t selUop;

    logic [`IQ_SIZE-1:0] wakeA;
    logic [`IQ_SIZE-1:0] wakeB;
    logic [`IQ_SIZE-1:0] ready;
    logic                selValid;
    logic [idxW-1:0]     selIdx;

    function automatic logic wakes(iqPkg::tag_t t, iqPkg::result_t bc, iqPkg::issueUop_t fw);
        logic hit;
        hit = bc.valid && bc.tagDst == t;
        // The single-cycle op in execute has its value one cycle later
        hit = hit || (fw.valid && fw.tagDst != iqPkg::NO_TAG && fw.tagDst == t);
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < `IQ_SIZE; i++) begin
            wakeA[i] = wakes(queue[i].tagA, bcast, fastWake);
            wakeB[i] = wakes(queue[i].opB.tagView.tag, bcast, fastWake);
            ready[i] = i < count
                && (queue[i].availA | wakeA[i])
                && (queue[i].availB | wakeB[i]);
        end
    end

    // Lowest ready index is the oldest ready entry
    always_comb begin
        selValid = 1'b0;
        selIdx   = '0;
        for (int i = `IQ_SIZE - 1; i >= 0; i--) begin
            if (ready[i]) begin
                selValid = 1'b1;
                selIdx   = idxW'(i);
            end
        end
    end

    always_comb begin
        iqPkg::iqEntry_t woke [`IQ_SIZE];
        iqPkg::iqEntry_t enq;
        logic            doIssue;
        logic [cntW-1:0] fill;

        for (int i = 0; i < `IQ_SIZE; i++) begin
            woke[i]        = queue[i];
            woke[i].availA = queue[i].availA | wakeA[i];
            woke[i].availB = queue[i].availB | wakeB[i];
        end

        selUop.valid  = selValid;
        selUop.aluOp  = woke[selIdx].aluOp;
        selUop.tagA   = woke[selIdx].tagA;
        selUop.opB    = woke[selIdx].opB;
        selUop.immB   = woke[selIdx].immB;
        selUop.tagDst = woke[selIdx].tagDst;
        selUop.sqN    = woke[selIdx].sqN;

        doIssue = selValid && !issueStall && !branch.taken;
        qNext   = woke;
        fill    = count;

        // Collapse the entries above the issued one
        if (doIssue) begin
            for (int j = 0; j < `IQ_SIZE - 1; j++) begin
                if (j >= int'(selIdx)) begin
                    qNext[j] = woke[j + 1];
                end
            end
            fill = count - 1'b1;
        end

        for (int k = 0; k < `IQ_DISPATCH; k++) begin
            enq = enqEntries[k];
            // Catch a result broadcast in the same cycle as enqueue
            enq.availA = enq.availA | wakes(enq.tagA, bcast, fastWake);
            enq.availB = enq.availB | wakes(enq.opB.tagView.tag, bcast, fastWake);
            if (enqValid[k] && !branch.taken) begin
                qNext[fill[idxW-1:0]] = enq;
                fill = fill + 1'b1;
            end
        end
        countNext = fill;

        // Keep everything up to the last entry not younger than the branch
        if (branch.taken) begin
            countNext = '0;
            for (int i = 0; i < `IQ_SIZE; i++) begin
                if (i < count && !iqPkg::isYounger(queue[i].sqN, branch.sqN)) begin
                    countNext = cntW'(i + 1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        queue <= qNext;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count          <= '0;
            issueReg.valid <= 1'b0;
        end else begin
            count <= countNext;
            if (branch.taken) begin
                if (!issueStall || iqPkg::isYounger(issueReg.sqN, branch.sqN)) begin
                    issueReg.valid <= 1'b0;
                end
            end else if (!issueStall) begin
                issueReg <= selUop;
            end
        end
    end

    assign freeSlots = cntW'(`IQ_SIZE) - count;

    // A held uop is taken by execute only once the stall drops
    always_comb begin
        issued       = issueReg;
        issued.valid = issueReg.valid && !issueStall;
    end

endmodule

`default_nettype wire

// ==== issueTb.sv ====
`default_nettype none
`include "iq_cfg.svh"

module issueTb;

    localparam int numTags = 2 ** `IQ_TAG_BITS;
    localparam int maxCmds = 128;

    logic                                 clk;
    logic                                 rst;
    iqPkg::renameUop_t [`IQ_DISPATCH-1:0] dispatch;
    iqPkg::branch_t                       branch;
    logic                                 issueStall = 1'b0;
    logic                                 initWe;
    iqPkg::tag_t                          initTag;
    logic [`IQ_DATA_BITS-1:0]             initData;
    logic [`IQ_DISPATCH-1:0]              stall;
    iqPkg::result_t                       result;

    // Parsed stim file, kind 0 init, 1 uop, 2 flush
    int                       cmdKind [maxCmds];
    iqPkg::renameUop_t        cmdUop [maxCmds];
    logic [`IQ_DATA_BITS-1:0] cmdData [maxCmds];
    logic [1:0]               expState [numTags];
    logic [`IQ_DATA_BITS-1:0] expValue [numTags];
    logic                     produced [numTags];
    iqPkg::renameUop_t        pending [$];

    int   numCmds;
    int   numExpected;
    int   stallCycles;
    int   tbErrors;
    int   seenCount;
    int   valueErrors;
    int   otherErrors;
    logic parsed;
    logic endScan;

    issueTop dut (
        .clk(clk), .rst(rst), .dispatch(dispatch), .branch(branch),
        .issueStall(issueStall), .initWe(initWe), .initTag(initTag),
        .initData(initData), .stall(stall), .result(result)
    );

    issueChecker resultCheck (
        .clk(clk), .rst(rst), .result(result), .expState(expState),
        .expValue(expValue), .endScan(endScan), .seenCount(seenCount),
        .valueErrors(valueErrors), .otherErrors(otherErrors)
    );

    always #2 clk = ~clk;

    // Random issue stall, about one cycle in three
    initial begin
        void'($urandom(32'h0b94_0d06));
        forever begin
            @(negedge clk);
            issueStall <= ($urandom % 3 == 0);
        end
    end

    // Register scoreboard, as a rename stage would keep it
    always @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < numTags; t++) produced[t] <= 1'b0;
        end else begin
            if (result.valid) produced[result.tagDst] <= 1'b1;
            if (initWe) produced[initTag] <= 1'b1;
        end
    end

    function automatic iqPkg::renameUop_t withAvail(iqPkg::renameUop_t u);
        u.availA = produced[u.tagA];
        u.availB = u.immB || produced[u.opB.tagView.tag];
        return u;
    endfunction

    task automatic readStim;
        int fd;
        int n;
        int op, tagA, immB, opB, tagDst, sqN, kill;
        logic [31:0] val;
        string kind;
        string rest;
        for (int t = 0; t < numTags; t++) begin
            expState[t] = 2'd0;
            expValue[t] = '0;
        end
        fd = $fopen("issue_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open issue_stim.txt");
            tbErrors++;
            return;
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            cmdUop[numCmds] = '0;
            if (kind == "init") begin
                n = $fscanf(fd, "%h %h", tagDst, val);
                cmdKind[numCmds]        = 0;
                cmdUop[numCmds].tagDst  = tagDst[5:0];
                cmdData[numCmds]        = val;
            end else if (kind == "uop") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                    op, tagA, immB, opB, tagDst, sqN, kill, val);
                if (n != 8) begin
                    $display("Malformed uop line in issue_stim.txt");
                    tbErrors++;
                end
                cmdKind[numCmds]          = 1;
                cmdUop[numCmds].valid     = 1'b1;
                cmdUop[numCmds].port      = iqPkg::PORT_INT;
                cmdUop[numCmds].aluOp     = iqPkg::aluOp_e'(op[2:0]);
                cmdUop[numCmds].tagA      = tagA[5:0];
                cmdUop[numCmds].immB      = immB[0];
                cmdUop[numCmds].opB.imm   = opB[7:0];
                cmdUop[numCmds].tagDst    = tagDst[5:0];
                cmdUop[numCmds].sqN       = sqN[5:0];
                expState[tagDst[5:0]] = kill[0] ? 2'd2 : 2'd1;
                expValue[tagDst[5:0]] = val;
                if (!kill[0]) numExpected++;
            end else if (kind == "flush") begin
                n = $fscanf(fd, "%h", sqN);
                cmdKind[numCmds]     = 2;
                cmdUop[numCmds].sqN  = sqN[5:0];
            end else begin
                // Comment line
                n = $fgets(rest, fd);
                continue;
            end
            numCmds++;
        end
        $fclose(fd);
    endtask

    // Holds each slot until the decoder takes it
    task automatic sendPending;
        while (pending.size() > 0) begin
            @(negedge clk);
            dispatch[0] = withAvail(pending[0]);
            dispatch[1] = pending.size() > 1 ? withAvail(pending[1]) : '0;
            #1;
            if (stall != '0) stallCycles++;
            if (!stall[0]) begin
                void'(pending.pop_front());
                if (dispatch[1].valid && !stall[1]) void'(pending.pop_front());
            end
        end
        @(negedge clk);
        dispatch = '0;
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        dispatch = '0;
        branch   = '0;
        initWe   = 1'b0;
        initTag  = '0;
        initData = '0;
        endScan  = 1'b0;
        parsed   = 1'b0;
        readStim();
        parsed = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int c = 0; c < numCmds; c++) begin
            if (cmdKind[c] == 1) begin
                pending.push_back(cmdUop[c]);
            end else begin
                sendPending();
                @(negedge clk);
                if (cmdKind[c] == 0) begin
                    initWe   = 1'b1;
                    initTag  = cmdUop[c].tagDst;
                    initData = cmdData[c];
                end else begin
                    branch = '{taken: 1'b1, sqN: cmdUop[c].sqN};
                end
                @(negedge clk);
                initWe = 1'b0;
                branch = '0;
            end
        end
        sendPending();

        while (seenCount < numExpected) @(negedge clk);
        // Window for stray broadcasts of flushed ops
        repeat (16) @(negedge clk);
        endScan = 1'b1;
        @(negedge clk);
        endScan = 1'b0;
        @(negedge clk);

        if (stallCycles == 0) begin
            $display("Dispatch stall never rose although the queue was overfilled");
            tbErrors++;
        end
        $display("Errors: %0d value, %0d other, %0d testbench; %0d of %0d results seen",
            valueErrors, otherErrors, tbErrors, seenCount, numExpected);
        if (valueErrors + otherErrors + tbErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (parsed);
        #(numCmds * 40 * 4);
        $display("Watchdog timeout after %0d cycles with results still missing",
            numCmds * 40);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== issueTop.sv ====
`default_nettype none
`include "iq_cfg.svh"

module issueTop (
    input  logic                                 clk,
    input  logic                                 rst,
    input  iqPkg::renameUop_t [`IQ_DISPATCH-1:0] dispatch,
    input  iqPkg::branch_t                       branch,
    input  logic                                 issueStall,
    input  logic                                 initWe,
    input  iqPkg::tag_t                          initTag,
    input  logic [`IQ_DATA_BITS-1:0]             initData,
    output logic [`IQ_DISPATCH-1:0]              stall,
    output iqPkg::result_t                       result
);

    iqPkg::iqEntry_t [`IQ_DISPATCH-1:0] enqEntries;
    logic [`IQ_DISPATCH-1:0]            enqValid;
    logic [$clog2(`IQ_SIZE+1)-1:0]      freeSlots;
    iqPkg::issueUop_t                   issuedUop;
    iqPkg::tag_t                        readTagA;
    iqPkg::tag_t                        readTagB;
    logic [`IQ_DATA_BITS-1:0]           readDataA;
    logic [`IQ_DATA_BITS-1:0]           readDataB;
    iqPkg::result_t                     exResult;
    iqPkg::result_t                     bcast;

    dispatchDecode decode (
        .dispatch(dispatch), .freeSlots(freeSlots), .branch(branch),
        .stall(stall), .enqEntries(enqEntries), .enqValid(enqValid)
    );

    // The uop in execute doubles as the fast wakeup source
    issueQueue iq (
        .clk(clk), .rst(rst), .enqEntries(enqEntries), .enqValid(enqValid),
        .branch(branch), .issueStall(issueStall), .bcast(bcast),
        .fastWake(issuedUop), .freeSlots(freeSlots), .issued(issuedUop)
    );

    intExecute exec (
        .clk(clk), .rst(rst), .issued(issuedUop), .branch(branch),
        .readTagA(readTagA), .readTagB(readTagB), .readDataA(readDataA),
        .readDataB(readDataB), .bcast(bcast), .exResult(exResult)
    );

    resultWriteback wb (
        .clk(clk), .rst(rst), .exResult(exResult), .readTagA(readTagA),
        .readTagB(readTagB), .readDataA(readDataA), .readDataB(readDataB),
        .initWe(initWe), .initTag(initTag), .initData(initData), .bcast(bcast)
    );

    assign result = bcast;

endmodule

`default_nettype wire

// ==== issue_asserts.sv ====
`default_nettype none
`include "iq_cfg.svh"

module issueAsserts (
    input logic                          clk,
    input logic                          rst,
    input logic                          issueStall,
    input iqPkg::branch_t                branch,
    input logic [$clog2(`IQ_SIZE+1)-1:0] count,
    input iqPkg::issueUop_t              issueReg
);

    countInRange: assert property (@(posedge clk) disable iff (rst) count <= `IQ_SIZE)
        else $error("Queue count %0d above depth", count);

    noIssueInReset: assert property (@(posedge clk) rst |=> !issueReg.valid)
        else $error("Issue register valid after a reset cycle");

    // A flush may still drop the held entry
    holdOnStall: assert property (@(posedge clk) disable iff (rst)
        issueStall && !branch.taken |=> $stable(issueReg))
        else $error("Issue register changed while issue stall was high");

endmodule

bind issueQueue issueAsserts queueChecks (
    .clk(clk), .rst(rst), .issueStall(issueStall), .branch(branch),
    .count(count), .issueReg(issueReg)
);

`default_nettype wire

// ==== issue_stim.txt ====
# init <tag> <value> | flush <branch sqN> | all fields hex, op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 slt 7 passB
# uop <op> <tagA> <immB> <opB> <tagDst> <sqN> <killed> <expected>
init 01 00000010
init 02 00000003
init 03 fffffff0
init 04 12345678
# Independent ops, then a dependent chain, sent back to back to fill the queue
uop 0 01 0 02 10 01 0 00000013
uop 1 01 0 02 11 02 0 0000000d
uop 2 04 1 f0 12 03 0 12345670
uop 3 02 0 04 13 04 0 1234567b
uop 4 04 1 ff 14 05 0 edcba987
uop 5 02 1 04 15 06 0 00000030
uop 6 03 0 01 16 07 0 00000001
uop 6 01 0 03 17 08 0 00000000
uop 7 01 1 80 18 09 0 ffffff80
uop 0 03 1 7f 19 0a 0 0000006f
uop 1 02 0 01 1a 0b 0 fffffff3
uop 5 01 0 02 1b 0c 0 00000080
uop 0 04 0 04 1c 0d 0 2468acf0
uop 4 01 0 03 1d 0e 0 ffffffe0
uop 3 01 1 01 1e 0f 0 00000011
uop 7 01 0 04 1f 10 0 12345678
uop 0 10 0 11 20 11 0 00000020
uop 5 20 1 02 21 12 0 00000080
uop 1 21 0 15 22 13 0 00000050
uop 4 22 0 21 23 14 0 000000d0
uop 0 23 1 f0 24 15 0 000000c0
# Ops past the branch wait on tag 28, which is produced only after the flush
uop 0 01 1 05 25 16 0 00000015
uop 0 28 0 01 26 18 1 00000000
uop 3 26 1 01 27 19 1 00000000
flush 17
uop 7 01 1 2a 28 18 0 0000002a
uop 0 28 0 25 29 19 0 0000003f

// ==== resultWriteback.sv ====
`default_nettype none
`include "iq_cfg.svh"

module resultWriteback (
    input  logic                     clk,
    input  logic                     rst,
    input  iqPkg::result_t           exResult,
    input  iqPkg::tag_t              readTagA,
    input  iqPkg::tag_t              readTagB,
    output logic [`IQ_DATA_BITS-1:0] readDataA,
    output logic [`IQ_DATA_BITS-1:0] readDataB,
    input  logic                     initWe,
    input  iqPkg::tag_t              initTag,
    input  logic [`IQ_DATA_BITS-1:0] initData,
    output iqPkg::result_t           bcast
);

    localparam int numRegs = 2 ** `IQ_TAG_BITS;

    // Physical register file, one entry per tag
    logic [`IQ_DATA_BITS-1:0] regFile [numRegs];

    // Execute results have priority over the init port
    always_ff @(posedge clk) begin
        if (exResult.valid) begin
            regFile[exResult.tagDst] <= exResult.value;
        end else if (initWe) begin
            regFile[initTag] <= initData;
        end
    end

    assign readDataA = regFile[readTagA];
    assign readDataB = regFile[readTagB];

    // Broadcast goes out on the same edge the value is written
    always_ff @(posedge clk) begin
        if (rst) begin
            bcast.valid <= 1'b0;
        end else begin
            bcast <= exResult;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module issueTb \
    -f filelist.f -o issueSim || exit 1
out=$(./obj_dir/issueSim)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
